//--- Makefile
TOP = trace_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -f vlog.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q -F '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- tests/trace_asserts.sv
// trace stream checker: start-up quiet time, tx hold, packet gap, record take, rx trigger
module trace_asserts #(
  parameter int INIT_TIME_OUT = 50,
  parameter int PACKET_DELAY  = 8
) (
  input logic                           clk,
  input logic                           reset,
  input logic                           stall,
  input logic [trace_pkg::STREAM_W-1:0] tx_data,
  input logic                           tx_valid,
  input logic                           tx_last,
  input logic                           tx_ready,
  input logic [trace_pkg::STREAM_W-1:0] rx_data,
  input logic                           rx_valid,
  input logic                           rx_last,
  input logic                           trigger
);

  int   fail_count = 0;   // polled by the testbench
  int   init_cnt;         // cycles since reset fell, saturating
  int   gap_cnt;          // quiet cycles still owed after a packet
  logic in_frame;
  logic frame_magic;      // current rx frame opened with the magic word
  logic exp_trig;

  ////////////////////
  // reference state
  ////////////////////

  always @(posedge clk) begin
    if (reset) begin
      init_cnt <= 0;
      gap_cnt  <= 0;
    end else begin
      if (init_cnt < INIT_TIME_OUT) init_cnt <= init_cnt + 1;
      if (tx_valid && tx_ready && tx_last) begin
        gap_cnt <= PACKET_DELAY;
      end else if (gap_cnt != 0) begin
        gap_cnt <= gap_cnt - 1;
      end
    end
  end

  // frame tracking on rx, trigger expected one cycle after the closing word
  always @(posedge clk) begin
    if (reset) begin
      in_frame    <= 1'b0;
      frame_magic <= 1'b0;
      exp_trig    <= 1'b0;
    end else begin
      exp_trig <= rx_valid && rx_last &&
                  (in_frame ? frame_magic : (rx_data == trace_pkg::TRIGGER_MAGIC));
      if (rx_valid) begin
        if (rx_last) begin
          in_frame <= 1'b0;
        end else if (!in_frame) begin
          in_frame    <= 1'b1;
          frame_magic <= (rx_data == trace_pkg::TRIGGER_MAGIC);
        end
      end
    end
  end

  ////////////////////
  // properties
  ////////////////////

  init_quiet: assert property (@(posedge clk) disable iff (reset)
    tx_valid |-> init_cnt >= INIT_TIME_OUT)
    else begin
      fail_count = fail_count + 1;
      $error("tx_valid high before the start-up time-out ran out");
    end

  tx_hold: assert property (@(posedge clk) disable iff (reset)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last))
    else begin
      fail_count = fail_count + 1;
      $error("tx word changed while the sink held it off");
    end

  packet_gap: assert property (@(posedge clk) disable iff (reset)
    gap_cnt != 0 |-> !tx_valid)
    else begin
      fail_count = fail_count + 1;
      $error("tx_valid high inside the inter-packet gap");
    end

  // the record is taken the cycle before its header, which frees the core
  take_no_stall: assert property (@(posedge clk) disable iff (reset)
    $rose(tx_valid) |-> !$past(stall))
    else begin
      fail_count = fail_count + 1;
      $error("core stalled in the cycle its record was taken");
    end

  trigger_pulse: assert property (@(posedge clk) disable iff (reset)
    trigger == exp_trig)
    else begin
      fail_count = fail_count + 1;
      $error("trigger is %b where %b was due", trigger, exp_trig);
    end

endmodule

//--- tests/trace_tb.sv
// trace subsystem testbench: random retirements under stall, tx back-pressure, rx frames
module trace_tb;

  localparam int XLEN           = 64;
  localparam int INIT_TIME_OUT  = 50;
  localparam int PACKET_DELAY   = 8;
  localparam int NUM_WORDS      = 3 + 2 * XLEN / 32;   // 7 words per packet
  localparam int NUM_RET        = 40;
  localparam int NUM_FRAMES     = 20;
  localparam int TIMEOUT_CYCLES = 2500;   // ~50 + 40 * (7*4 + 8 + 10) plus headroom
  localparam int DRAIN_LIMIT    = 2 * (NUM_WORDS * 4 + PACKET_DELAY + 10);   // two records queued
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic                  clk;
  logic                  reset;
  logic                  retire;
  logic [XLEN-1:0]       pc;
  logic [31:0]           instr;
  trace_pkg::priv_mode_t priv;
  logic                  trap;
  logic                  gpr_wen;
  logic [4:0]            gpr_addr;
  logic [XLEN-1:0]       gpr_value;
  logic                  stall;
  logic [31:0]           tx_data;
  logic                  tx_valid;
  logic                  tx_last;
  logic                  tx_ready;
  logic [31:0]           rx_data;
  logic                  rx_valid;
  logic                  rx_last;
  logic                  trigger;

  logic [31:0] lfsr = 32'h2133;
  logic [31:0] exp_q[$];          // expected tx words, oldest first
  logic [31:0] acc_count = '0;    // accepted retirements so far
  int          cycles = 0;
  int          packets = 0;
  int          word_idx = 0;
  int          issued = 0;
  int          ret_gap = 0;
  int          drain = 0;         // cycles since the last retirement went in
  int          rx_left = 0;
  int          rx_frames = 0;
  logic        rx_first = 1'b0;
  logic        taken = 1'b0;      // retirement went in at the last edge

  trace_top #(
    .XLEN(XLEN),
    .INIT_TIME_OUT(INIT_TIME_OUT),
    .PACKET_DELAY(PACKET_DELAY)
  ) dut (
    .clk, .reset, .retire, .pc, .instr, .priv, .trap, .gpr_wen, .gpr_addr, .gpr_value,
    .stall, .tx_data, .tx_valid, .tx_last, .tx_ready, .rx_data, .rx_valid, .rx_last,
    .trigger
  );

  bind trace_top trace_asserts #(
    .INIT_TIME_OUT(INIT_TIME_OUT),
    .PACKET_DELAY(PACKET_DELAY)
  ) checks (
    .clk(clk), .reset(reset), .stall(stall), .tx_data(tx_data), .tx_valid(tx_valid),
    .tx_last(tx_last), .tx_ready(tx_ready), .rx_data(rx_data), .rx_valid(rx_valid),
    .rx_last(rx_last), .trigger(trigger)
  );

  ////////////////////
  // helpers
  ////////////////////

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ LFSR_TAPS;
      r = {r[30:0], b};
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("FAILED time=%0t %s expected %h actual %h", $time, name, exp_val, act_val);
    $display("*** FAILED ***");
    $fatal(1, "stopping on first error");
  endtask

  task automatic stop_with_failure(input string what);
    $display("time=%0t %s", $time, what);
    $display("*** FAILED ***");
    $fatal(1, "stopping on first error");
  endtask

  task automatic drive_record();
    pc[31:0]         = rand_bits(32);
    pc[63:32]        = rand_bits(32);
    instr            = rand_bits(32);
    case (rand_bits(2))
      32'd0:   priv = trace_pkg::U;
      32'd1:   priv = trace_pkg::S;
      default: priv = trace_pkg::M;
    endcase
    trap             = 1'(rand_bits(1));
    gpr_wen          = 1'(rand_bits(1));
    gpr_addr         = 5'(rand_bits(5));
    gpr_value[31:0]  = rand_bits(32);
    gpr_value[63:32] = rand_bits(32);
    retire           = 1'b1;
  endtask

  ////////////////////
  // clock, watchdog
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d of %0d packets out, %0d of %0d frames sent",
               cycles, packets, NUM_RET, rx_frames, NUM_FRAMES);
      $display("*** FAILED ***");
      $fatal(1, "run did not finish");
    end
  end

  ////////////////////
  // mid-cycle monitor
  ////////////////////

  // everything is stable at the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      if (dut.checks.fail_count != 0) begin
        stop_with_failure("a bound assertion on the tx or rx stream failed");
      end else if (tx_valid && tx_ready && exp_q.size() == 0) begin
        stop_with_failure("tx word sent with no accepted retirement behind it");
      end else if (tx_valid && tx_ready && tx_data !== exp_q[0]) begin
        report_mismatch("tx_data", exp_q[0], tx_data);
      end else if (tx_valid && tx_ready && tx_last !== (word_idx == NUM_WORDS - 1)) begin
        report_mismatch("tx_last", 32'(word_idx == NUM_WORDS - 1), 32'(tx_last));
      end else begin
        if (tx_valid && tx_ready) begin
          void'(exp_q.pop_front());
          if (tx_last) begin
            packets  = packets + 1;
            word_idx = 0;
          end else begin
            word_idx = word_idx + 1;
          end
        end
        if (retire && !stall) begin   // accepted at the coming edge
          acc_count = acc_count + 32'd1;
          exp_q.push_back({trace_pkg::TRACE_TAG, 14'd0, priv, trap, gpr_wen, 1'b0, gpr_addr});
          exp_q.push_back(instr);
          exp_q.push_back(pc[31:0]);
          exp_q.push_back(pc[63:32]);
          exp_q.push_back(gpr_value[31:0]);
          exp_q.push_back(gpr_value[63:32]);
          exp_q.push_back(acc_count);
          taken = 1'b1;
        end
      end
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    reset     = 1'b1;
    retire    = 1'b0;
    pc        = '0;
    instr     = '0;
    priv      = trace_pkg::M;
    trap      = 1'b0;
    gpr_wen   = 1'b0;
    gpr_addr  = '0;
    gpr_value = '0;
    tx_ready  = 1'b0;
    rx_data   = '0;
    rx_valid  = 1'b0;
    rx_last   = 1'b0;
    repeat (4) @(posedge clk);
    #2 reset = 1'b0;
    while (!(issued == NUM_RET && !retire && rx_frames == NUM_FRAMES &&
             (exp_q.size() == 0 || drain >= DRAIN_LIMIT))) begin
      @(posedge clk);
      #2;
      // core side, fields held while stalled
      if (taken) begin
        retire = 1'b0;
        taken  = 1'b0;
      end
      if (issued == NUM_RET && !retire) drain = drain + 1;
      if (!retire && issued < NUM_RET) begin
        if (ret_gap == 0) begin
          drive_record();
          issued  = issued + 1;
          ret_gap = int'(rand_bits(2));
        end else begin
          ret_gap = ret_gap - 1;
        end
      end
      tx_ready = (rand_bits(2) != 0);   // low a quarter of the time
      // rx frames of 1 to 4 words with holes
      rx_valid = 1'b0;
      rx_last  = 1'b0;
      rx_data  = rand_bits(32);
      if (rx_left == 0 && rx_frames < NUM_FRAMES && rand_bits(1) != 0) begin
        rx_left  = int'(rand_bits(2)) + 1;
        rx_first = 1'b1;
      end
      if (rx_left != 0 && rand_bits(2) != 0) begin
        rx_valid = 1'b1;
        if (rx_first && rand_bits(1) != 0) rx_data = trace_pkg::TRIGGER_MAGIC;
        rx_first = 1'b0;
        rx_left  = rx_left - 1;
        rx_last  = (rx_left == 0);
        if (rx_last) rx_frames = rx_frames + 1;
      end
    end
    rx_valid = 1'b0;
    repeat (4) @(posedge clk);   // let the last trigger check run
    if (packets != NUM_RET || exp_q.size() != 0) begin
      $display("%0d packets missing, %0d words never sent", NUM_RET - packets, exp_q.size());
      $display("*** FAILED ***");
      $fatal(1, "lost trace records");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

//--- verilog/trace_capture.sv
// retired-instruction capture: one record register, retirement count and core stall
module trace_capture #(
  parameter int XLEN = 64
) (
  input  logic                  clk,
  input  logic                  reset,

  // core retirement side
  input  logic                  retire,
  input  logic [XLEN-1:0]       pc,
  input  logic [31:0]           instr,
  input  trace_pkg::priv_mode_t priv,
  input  logic                  trap,
  input  logic                  gpr_wen,
  input  logic [4:0]            gpr_addr,
  input  logic [XLEN-1:0]       gpr_value,
  output logic                  stall,

  // record handed to the packetizer
  input  logic                  rec_take,
  output logic                  rec_valid,
  output logic [XLEN-1:0]       rec_pc,
  output logic [31:0]           rec_instr,
  output trace_pkg::priv_mode_t rec_priv,
  output logic                  rec_trap,
  output logic                  rec_gpr_wen,
  output logic [4:0]            rec_gpr_addr,
  output logic [XLEN-1:0]       rec_gpr_value,
  output logic [31:0]           rec_count
);

  logic accept;   // retirement actually taken this cycle

  ////////////////////
  // handshake with the core
  ////////////////////

  // a record leaving this cycle frees the slot for a new one
  assign stall  = rec_valid & ~rec_take;
  assign accept = retire & ~stall;

  // full flag
  always_ff @(posedge clk) begin
    if (reset) begin
      rec_valid <= 1'b0;
    end else if (accept) begin
      rec_valid <= 1'b1;          // refill wins over take
    end else if (rec_take) begin
      rec_valid <= 1'b0;
    end
  end

  // accepted retirements, loaded value travels with the record
  always_ff @(posedge clk) begin
    if (reset) begin
      rec_count <= '0;
    end else if (accept) begin
      rec_count <= rec_count + 32'd1;
    end
  end

  ////////////////////
  // record payload
  ////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      rec_pc        <= pc;
      rec_instr     <= instr;
      rec_priv      <= priv;
      rec_trap      <= trap;
      rec_gpr_wen   <= gpr_wen;
      rec_gpr_addr  <= gpr_addr;
      rec_gpr_value <= gpr_value;   // kept even without a write
    end
  end

endmodule

//--- verilog/trace_packetizer.sv
// trace packetizer: start-up time-out, record to word stream serializer, inter-packet gap
module trace_packetizer #(
  parameter int XLEN          = 64,
  parameter int INIT_TIME_OUT = 1000,
  parameter int PACKET_DELAY  = 400
) (
  input  logic                           clk,
  input  logic                           reset,

  // record from capture
  input  logic                           rec_valid,
  input  logic [XLEN-1:0]                rec_pc,
  input  logic [31:0]                    rec_instr,
  input  trace_pkg::priv_mode_t          rec_priv,
  input  logic                           rec_trap,
  input  logic                           rec_gpr_wen,
  input  logic [4:0]                     rec_gpr_addr,
  input  logic [XLEN-1:0]                rec_gpr_value,
  input  logic [31:0]                    rec_count,
  output logic                           rec_take,

  // tx word stream
  output logic [trace_pkg::STREAM_W-1:0] tx_data,
  output logic                           tx_valid,
  output logic                           tx_last,
  input  logic                           tx_ready
);

  localparam int SW        = trace_pkg::STREAM_W;
  localparam int XW        = XLEN / SW;                 // words per xlen field
  localparam int NUM_WORDS = 3 + 2 * XW;                // header, instr, pc, gpr, count
  localparam int IDX_W     = $clog2(NUM_WORDS);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_WORDS - 1);

  // one down-counter serves both the time-out and the gap
  localparam int CNT_MAX = (INIT_TIME_OUT > PACKET_DELAY) ? INIT_TIME_OUT : PACKET_DELAY;
  localparam int CNT_W   = $clog2(CNT_MAX + 2);

  trace_pkg::pkt_state_t      state;
  logic [CNT_W-1:0]           cnt;
  logic [IDX_W-1:0]           idx;        // word being offered
  logic [SW-1:0]              header;
  logic [NUM_WORDS*SW-1:0]    pkt_words;  // whole packet, word 0 in the low bits
  logic                       handshake;

  ////////////////////
  // header assembly
  ////////////////////

  always_comb begin
    header = '0;
    header[trace_pkg::HDR_TAG_LSB +: 8]  = trace_pkg::TRACE_TAG;
    header[trace_pkg::HDR_PRIV_LSB +: 2] = rec_priv;
    header[trace_pkg::HDR_TRAP_BIT]      = rec_trap;
    header[trace_pkg::HDR_WEN_BIT]       = rec_gpr_wen;
    header[trace_pkg::HDR_ADDR_LSB +: 5] = rec_gpr_addr;
  end

  // snapshot of the record, frees capture for the next one
  always_ff @(posedge clk) begin
    if (rec_take) begin
      pkt_words <= {rec_count, rec_gpr_value, rec_pc, rec_instr, header};
    end
  end

  ////////////////////
  // stream outputs
  ////////////////////

  assign rec_take  = (state == trace_pkg::IDLE) & rec_valid;
  assign tx_valid  = (state == trace_pkg::SEND);
  assign tx_last   = tx_valid & (idx == LAST_IDX);
  assign handshake = tx_valid & tx_ready;

  // low xlen word first falls out of the packing order
  assign tx_data = pkt_words[SW*int'(idx) +: SW];

  ////////////////////
  // control FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= trace_pkg::INIT;
      cnt   <= CNT_W'(INIT_TIME_OUT);
      idx   <= '0;
    end else begin
      case (state)
        trace_pkg::INIT: begin
          cnt <= cnt - 1'b1;
          if (cnt <= CNT_W'(1)) state <= trace_pkg::IDLE;   // last init cycle
        end
        trace_pkg::IDLE: begin
          if (rec_valid) state <= trace_pkg::SEND;           // header out next cycle
        end
        trace_pkg::SEND: begin
          if (handshake) begin
            if (tx_last) begin
              idx   <= '0;
              cnt   <= CNT_W'(PACKET_DELAY);
              state <= (PACKET_DELAY == 0) ? trace_pkg::IDLE : trace_pkg::GAP;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        trace_pkg::GAP: begin
          cnt <= cnt - 1'b1;
          if (cnt <= CNT_W'(1)) state <= trace_pkg::IDLE;
        end
        default: state <= trace_pkg::IDLE;
      endcase
    end
  end

endmodule

//--- verilog/trace_pkg.sv
// trace package: stream width, packet tag, header layout and state encodings
package trace_pkg;

  ////////////////////
  // stream and packet constants
  ////////////////////

  localparam int STREAM_W = 32;                 // tx and rx word width

  localparam logic [7:0] TRACE_TAG = 8'hA5;     // top byte of every header word

  // first word of a frame that fires the debug trigger
  localparam logic [STREAM_W-1:0] TRIGGER_MAGIC = 32'h7472_6967;

  ////////////////////
  // header word layout
  ////////////////////

  // tag 31:24, priv 9:8, trap 7, gpr write 6, gpr addr 4:0, rest zero
  localparam int HDR_TAG_LSB  = 24;
  localparam int HDR_PRIV_LSB = 8;
  localparam int HDR_TRAP_BIT = 7;
  localparam int HDR_WEN_BIT  = 6;
  localparam int HDR_ADDR_LSB = 0;

  ////////////////////
  // encodings
  ////////////////////

  // risc-v privilege levels, 2 is reserved
  typedef enum logic [1:0] {
    U = 2'd0,
    S = 2'd1,
    M = 2'd3
  } priv_mode_t;

  typedef enum logic [1:0] {
    INIT,    // waiting out the start-up time-out
    IDLE,    // ready for the next record
    SEND,    // words going out on tx
    GAP      // quiet time between packets
  } pkt_state_t;

  typedef enum logic [1:0] {
    FIRST,   // next valid word opens a frame
    MATCH,   // frame opened with the magic word
    SKIP     // frame opened with anything else
  } trig_state_t;

endpackage

//--- verilog/trace_top.sv
// trace top level: retirement capture, tx packetizer and rx trigger generator
module trace_top #(
  parameter int XLEN          = 64,
  parameter int INIT_TIME_OUT = 1000,
  parameter int PACKET_DELAY  = 400
) (
  input  logic                           clk,
  input  logic                           reset,

  // core retirement side
  input  logic                           retire,
  input  logic [XLEN-1:0]                pc,
  input  logic [31:0]                    instr,
  input  trace_pkg::priv_mode_t          priv,
  input  logic                           trap,
  input  logic                           gpr_wen,
  input  logic [4:0]                     gpr_addr,
  input  logic [XLEN-1:0]                gpr_value,
  output logic                           stall,

  // tx stream toward the mac
  output logic [trace_pkg::STREAM_W-1:0] tx_data,
  output logic                           tx_valid,
  output logic                           tx_last,
  input  logic                           tx_ready,

  // rx stream from the mac, always accepted
  input  logic [trace_pkg::STREAM_W-1:0] rx_data,
  input  logic                           rx_valid,
  input  logic                           rx_last,
  output logic                           trigger
);

  ////////////////////
  // capture to packetizer
  ////////////////////

  logic                  rec_valid;
  logic                  rec_take;
  logic [XLEN-1:0]       rec_pc;
  logic [31:0]           rec_instr;
  trace_pkg::priv_mode_t rec_priv;
  logic                  rec_trap;
  logic                  rec_gpr_wen;
  logic [4:0]            rec_gpr_addr;
  logic [XLEN-1:0]       rec_gpr_value;
  logic [31:0]           rec_count;

  trace_capture #(.XLEN(XLEN)) capture (
    .clk, .reset, .retire, .pc, .instr, .priv, .trap, .gpr_wen, .gpr_addr, .gpr_value,
    .stall, .rec_take, .rec_valid, .rec_pc, .rec_instr, .rec_priv, .rec_trap,
    .rec_gpr_wen, .rec_gpr_addr, .rec_gpr_value, .rec_count
  );

  trace_packetizer #(
    .XLEN(XLEN),
    .INIT_TIME_OUT(INIT_TIME_OUT),
    .PACKET_DELAY(PACKET_DELAY)
  ) packetizer (
    .clk, .reset, .rec_valid, .rec_pc, .rec_instr, .rec_priv, .rec_trap,
    .rec_gpr_wen, .rec_gpr_addr, .rec_gpr_value, .rec_count, .rec_take,
    .tx_data, .tx_valid, .tx_last, .tx_ready
  );

  ////////////////////
  // rx side
  ////////////////////

  trigger_gen triggergen (
    .clk, .reset, .rx_data, .rx_valid, .rx_last, .trigger
  );

endmodule

//--- verilog/trigger_gen.sv
// trigger generator: pulses the debug trigger after an rx frame that opens with the magic word
module trigger_gen (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [trace_pkg::STREAM_W-1:0] rx_data,
  input  logic                           rx_valid,
  input  logic                           rx_last,
  output logic                           trigger
);

  trace_pkg::trig_state_t state;
  logic                   first_hit;   // current word is magic
  logic                   in_match;    // frame so far qualifies

  ////////////////////
  // frame qualification
  ////////////////////

  assign first_hit = (rx_data == trace_pkg::TRIGGER_MAGIC);

  // a one-word frame is judged on its only word
  assign in_match = (state == trace_pkg::MATCH) |
                    ((state == trace_pkg::FIRST) & first_hit);

  ////////////////////
  // frame tracker
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= trace_pkg::FIRST;
    end else if (rx_valid) begin
      if (rx_last) begin
        state <= trace_pkg::FIRST;     // frame closed
      end else if (state == trace_pkg::FIRST) begin
        state <= first_hit ? trace_pkg::MATCH : trace_pkg::SKIP;
      end
    end
  end

  // one-cycle pulse after the closing word
  always_ff @(posedge clk) begin
    if (reset) begin
      trigger <= 1'b0;
    end else begin
      trigger <= rx_valid & rx_last & in_match;
    end
  end

endmodule

//--- vlog.f
verilog/trace_pkg.sv
verilog/trace_capture.sv
verilog/trace_packetizer.sv
verilog/trigger_gen.sv
verilog/trace_top.sv
tests/trace_asserts.sv
tests/trace_tb.sv
